//--- rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // =========================================================================
    // Instruction geometry
    // =========================================================================
    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int opcodeW  = 7;
    localparam int funct3W  = 3;

    // =========================================================================
    // Major opcodes, instr[6:0]
    // =========================================================================
    localparam logic [opcodeW-1:0] opLoad   = 7'b0000011;
    localparam logic [opcodeW-1:0] opStore  = 7'b0100011;
    localparam logic [opcodeW-1:0] opBranch = 7'b1100011;
    localparam logic [opcodeW-1:0] opJal    = 7'b1101111;
    localparam logic [opcodeW-1:0] opJalr   = 7'b1100111;
    localparam logic [opcodeW-1:0] opOpImm  = 7'b0010011;
    localparam logic [opcodeW-1:0] opOp     = 7'b0110011;
    localparam logic [opcodeW-1:0] opLui    = 7'b0110111;
    localparam logic [opcodeW-1:0] opAuipc  = 7'b0010111;

    // Branch conditions, instr[14:12]
    localparam logic [funct3W-1:0] f3Beq  = 3'b000;
    localparam logic [funct3W-1:0] f3Bne  = 3'b001;
    localparam logic [funct3W-1:0] f3Blt  = 3'b100;
    localparam logic [funct3W-1:0] f3Bge  = 3'b101;
    localparam logic [funct3W-1:0] f3Bltu = 3'b110;
    localparam logic [funct3W-1:0] f3Bgeu = 3'b111;

endpackage

`default_nettype wire

//--- ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // Operand A source
    localparam logic selRs1 = 1'b0;
    localparam logic selPc  = 1'b1;
    // Operand B source
    localparam logic selRs2 = 1'b0;
    localparam logic selImm = 1'b1;

    typedef enum logic [2:0] {
        immI = 3'd0,
        immS = 3'd1,
        immB = 3'd2,
        immU = 3'd3,
        immJ = 3'd4
    } immSelT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpT;

    typedef enum logic [1:0] {
        wbMem = 2'd0,
        wbAlu = 2'd1,
        wbPc4 = 2'd2
    } wbSelT;

    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdWb   = 2'd1,
        fwdMem  = 2'd2
    } fwdSelT;

    // =========================================================================
    // Stage payloads, each nests the payload of the next stage
    // =========================================================================
    typedef struct packed {
        logic                           regWen;
        wbSelT                          wbSel;
        logic [rvIsaPkg::regAddrW-1:0]  rd;
    } wbCtrlT;

    typedef struct packed {
        logic [rvIsaPkg::funct3W-1:0]   funct3;
        logic                           memWrite;
        logic                           isBranch;
        logic                           isJump;
        logic                           predTaken;   // Fetch guess, checked in MEM
        wbCtrlT                         wb;
    } memCtrlT;

    typedef struct packed {
        aluOpT                          aluOp;
        logic                           aluASel;
        logic                           aluBSel;
        memCtrlT                        mem;
        logic [rvIsaPkg::regAddrW-1:0]  rs1;
        logic [rvIsaPkg::regAddrW-1:0]  rs2;
        logic                           useRs1;
        logic                           useRs2;
    } exCtrlT;

endpackage

`default_nettype wire

//--- stageIf.sv
`timescale 1ns/1ps
`default_nettype none

// Destination state of one pipeline stage, as seen by the hazard logic
interface stageIf;
    import rvIsaPkg::*;

    logic                regWen;
    logic [regAddrW-1:0] rd;
    logic                isLoad;     // Result only arrives from memory
    logic                valid;      // Stage holds an instruction, not a bubble

    modport src (
        output regWen,
        output rd,
        output isLoad,
        output valid
    );

    modport snk (
        input regWen,
        input rd,
        input isLoad,
        input valid
    );

endinterface

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  logic [rvIsaPkg::xlen-1:0] instr,
    input  logic                      predTaken,
    output ctrlPkg::immSelT           immSel,
    output ctrlPkg::exCtrlT           exCtrl
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    logic [opcodeW-1:0]  opcode;
    logic [funct3W-1:0]  funct3;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic                altFn;
    aluOpT               aluFn;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign altFn  = instr[30];      // SUB and SRA/SRAI

    // ALU function shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  aluFn = (opcode == opOp && altFn) ? aluSub : aluAdd;
            3'b001:  aluFn = aluSll;
            3'b010:  aluFn = aluSlt;
            3'b011:  aluFn = aluSltu;
            3'b100:  aluFn = aluXor;
            3'b101:  aluFn = altFn ? aluSra : aluSrl;
            3'b110:  aluFn = aluOr;
            default: aluFn = aluAnd;
        endcase
    end

    always_comb begin
        exCtrl = '0;
        immSel = immI;
        case (opcode)
            opLoad, opStore: begin
                immSel              = (opcode == opStore) ? immS : immI;
                exCtrl.aluBSel      = selImm;
                exCtrl.rs1          = rs1;
                exCtrl.useRs1       = 1'b1;
                exCtrl.mem.funct3   = funct3;
                if (opcode == opStore) begin
                    exCtrl.rs2          = rs2;      // Store data
                    exCtrl.useRs2       = 1'b1;
                    exCtrl.mem.memWrite = 1'b1;
                    exCtrl.mem.wb.wbSel = wbAlu;    // Keeps wbMem for loads only
                end else begin
                    exCtrl.mem.wb.regWen = 1'b1;
                    exCtrl.mem.wb.wbSel  = wbMem;
                    exCtrl.mem.wb.rd     = rd;
                end
            end
            opBranch: begin
                immSel               = immB;
                exCtrl.aluASel       = selPc;       // Target is PC + imm
                exCtrl.aluBSel       = selImm;
                exCtrl.rs1           = rs1;
                exCtrl.rs2           = rs2;
                exCtrl.useRs1        = 1'b1;
                exCtrl.useRs2        = 1'b1;
                exCtrl.mem.funct3    = funct3;
                exCtrl.mem.isBranch  = 1'b1;
                exCtrl.mem.predTaken = predTaken;
                exCtrl.mem.wb.wbSel  = wbAlu;
            end
            opJal, opJalr: begin
                immSel               = (opcode == opJal) ? immJ : immI;
                exCtrl.aluASel       = (opcode == opJal) ? selPc : selRs1;
                exCtrl.aluBSel       = selImm;
                exCtrl.rs1           = (opcode == opJalr) ? rs1 : '0;
                exCtrl.useRs1        = (opcode == opJalr);
                exCtrl.mem.isJump    = 1'b1;
                exCtrl.mem.predTaken = predTaken;
                exCtrl.mem.wb.regWen = 1'b1;
                exCtrl.mem.wb.wbSel  = wbPc4;       // Link address
                exCtrl.mem.wb.rd     = rd;
            end
            opOpImm, opOp: begin
                exCtrl.aluOp         = aluFn;
                exCtrl.aluBSel       = (opcode == opOpImm) ? selImm : selRs2;
                exCtrl.rs1           = rs1;
                exCtrl.useRs1        = 1'b1;
                exCtrl.rs2           = (opcode == opOp) ? rs2 : '0;
                exCtrl.useRs2        = (opcode == opOp);
                exCtrl.mem.wb.regWen = 1'b1;
                exCtrl.mem.wb.wbSel  = wbAlu;
                exCtrl.mem.wb.rd     = rd;
            end
            opLui, opAuipc: begin
                immSel               = immU;
                exCtrl.aluASel       = (opcode == opAuipc) ? selPc : selRs1;
                exCtrl.aluBSel       = selImm;
                exCtrl.mem.wb.regWen = 1'b1;
                exCtrl.mem.wb.wbSel  = wbAlu;
                exCtrl.mem.wb.rd     = rd;
            end
            default: ;      // FENCE, SYSTEM and unknown opcodes become bubbles
        endcase

        // x0 is never written
        if (exCtrl.mem.wb.rd == '0) begin
            exCtrl.mem.wb.regWen = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

// One pipeline stage register, payload type chosen per stage
module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    hold,
    input  payloadT d,
    output payloadT q
);

    // All-zero payload is a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [rvIsaPkg::regAddrW-1:0] idRs1,
    input  logic [rvIsaPkg::regAddrW-1:0] idRs2,
    input  logic                          idUse1,
    input  logic                          idUse2,
    input  logic [rvIsaPkg::regAddrW-1:0] exRs1,
    input  logic [rvIsaPkg::regAddrW-1:0] exRs2,
    input  logic                          exUse1,
    input  logic                          exUse2,
    input  logic                          exMemWrite,
    stageIf.snk                           exStage,
    stageIf.snk                           memStage,
    stageIf.snk                           wbStage,
    output ctrlPkg::fwdSelT               fwdA,
    output ctrlPkg::fwdSelT               fwdB,
    output ctrlPkg::fwdSelT               fwdStore,
    output logic                          stall
);
    import rvIsaPkg::*;
    import ctrlPkg::*;

    logic   memFwdOk;
    logic   wbFwdOk;
    logic   exLoadRd;
    fwdSelT selRs2;

    // A MEM load has no data yet, the stall keeps that case out of EX
    assign memFwdOk = memStage.valid && memStage.regWen && !memStage.isLoad
                      && memStage.rd != '0;
    assign wbFwdOk  = wbStage.valid && wbStage.regWen && wbStage.rd != '0;

    // Youngest producer wins
    function automatic fwdSelT pickSrc(input logic [regAddrW-1:0] rs, input logic srcUsed);
        fwdSelT sel;
        sel = fwdNone;
        if (srcUsed && rs != '0) begin
            if (memFwdOk && memStage.rd == rs) begin
                sel = fwdMem;
            end else if (wbFwdOk && wbStage.rd == rs) begin
                sel = fwdWb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA     = pickSrc(exRs1, exUse1);
        selRs2   = pickSrc(exRs2, exUse2);
        fwdB     = exMemWrite ? fwdNone : selRs2;
        fwdStore = exMemWrite ? selRs2 : fwdNone;   // Store data path
    end

    // =========================================================================
    // Load-use detection against the instruction still in ID
    // =========================================================================
    assign exLoadRd = exStage.valid && exStage.isLoad && exStage.regWen && exStage.rd != '0;
    assign stall    = exLoadRd && ((idUse1 && idRs1 == exStage.rd)
                                   || (idUse2 && idRs2 == exStage.rd));

endmodule

`default_nettype wire

//--- branchResolver.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  ctrlPkg::memCtrlT memCtrl,
    input  logic             brEq,
    input  logic             brLt,
    output logic             redirect,
    output logic             branchResolved,
    output logic             actualTaken,
    output logic             mispredict
);
    import rvIsaPkg::*;

    logic condMet;

    // Signedness already applied by the comparator
    always_comb begin
        case (memCtrl.funct3)
            f3Beq:         condMet = brEq;
            f3Bne:         condMet = !brEq;
            f3Blt, f3Bltu: condMet = brLt;
            f3Bge, f3Bgeu: condMet = !brLt;
            default:       condMet = 1'b0;
        endcase
    end

    always_comb begin
        redirect       = 1'b0;
        branchResolved = 1'b0;
        actualTaken    = 1'b0;
        mispredict     = 1'b0;
        if (memCtrl.isJump) begin
            // Always taken, only a missed prediction needs a new fetch
            actualTaken = 1'b1;
            redirect    = !memCtrl.predTaken;
        end else if (memCtrl.isBranch) begin
            branchResolved = 1'b1;
            actualTaken    = condMet;
            mispredict     = condMet != memCtrl.predTaken;
            redirect       = condMet != memCtrl.predTaken;
        end
    end

endmodule

`default_nettype wire

//--- pipeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCtrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rvIsaPkg::xlen-1:0]     instr,
    input  logic                          predTaken,
    input  logic                          brEq,
    input  logic                          brLt,
    output ctrlPkg::immSelT               immSel,
    output ctrlPkg::aluOpT                aluOp,
    output logic                          aluASel,
    output logic                          aluBSel,
    output logic [rvIsaPkg::funct3W-1:0]  memFunct3,
    output logic                          memWrite,
    output logic                          regWen,
    output ctrlPkg::wbSelT                wbSel,
    output logic [rvIsaPkg::regAddrW-1:0] wbRd,
    output ctrlPkg::fwdSelT               fwdA,
    output ctrlPkg::fwdSelT               fwdB,
    output ctrlPkg::fwdSelT               fwdStore,
    output logic                          stall,
    output logic                          redirect,
    output logic                          branchResolved,
    output logic                          actualTaken,
    output logic                          mispredict
);
    import ctrlPkg::*;

    exCtrlT  idCtrl;
    exCtrlT  exCtrl;
    memCtrlT memCtrl;
    wbCtrlT  wbCtrl;
    logic    memBrEq;
    logic    memBrLt;
    logic    loadUse;
    logic    exFlush;

    stageIf exStage ();
    stageIf memStage ();
    stageIf wbStage ();

    instrDecoder i_instrDecoder (.instr, .predTaken, .immSel, .exCtrl(idCtrl));

    // =========================================================================
    // Stage registers
    // =========================================================================
    assign stall   = loadUse && !redirect;      // Wrong-path ID never stalls
    assign exFlush = redirect || stall;

    pipeReg #(.payloadT(exCtrlT)) i_exReg (
        .clk, .rst, .flush(exFlush), .hold(1'b0), .d(idCtrl), .q(exCtrl)
    );
    pipeReg #(.payloadT(memCtrlT)) i_memReg (
        .clk, .rst, .flush(redirect), .hold(1'b0), .d(exCtrl.mem), .q(memCtrl)
    );
    pipeReg #(.payloadT(wbCtrlT)) i_wbReg (
        .clk, .rst, .flush(1'b0), .hold(1'b0), .d(memCtrl.wb), .q(wbCtrl)
    );

    // Comparator result follows its instruction out of EX
    always_ff @(posedge clk) begin
        memBrEq <= brEq;
        memBrLt <= brLt;
    end

    assign exStage.regWen  = exCtrl.mem.wb.regWen;
    assign exStage.rd      = exCtrl.mem.wb.rd;
    assign exStage.isLoad  = exCtrl.mem.wb.wbSel == wbMem;
    assign exStage.valid   = exCtrl != '0;
    assign memStage.regWen = memCtrl.wb.regWen;
    assign memStage.rd     = memCtrl.wb.rd;
    assign memStage.isLoad = memCtrl.wb.wbSel == wbMem;
    assign memStage.valid  = memCtrl != '0;
    assign wbStage.regWen  = wbCtrl.regWen;
    assign wbStage.rd      = wbCtrl.rd;
    assign wbStage.isLoad  = wbCtrl.wbSel == wbMem;
    assign wbStage.valid   = wbCtrl != '0;

    hazardUnit i_hazardUnit (
        .idRs1(idCtrl.rs1), .idRs2(idCtrl.rs2), .idUse1(idCtrl.useRs1), .idUse2(idCtrl.useRs2),
        .exRs1(exCtrl.rs1), .exRs2(exCtrl.rs2), .exUse1(exCtrl.useRs1), .exUse2(exCtrl.useRs2),
        .exMemWrite(exCtrl.mem.memWrite), .exStage(exStage), .memStage(memStage),
        .wbStage(wbStage), .fwdA, .fwdB, .fwdStore, .stall(loadUse)
    );

    branchResolver i_branchResolver (
        .memCtrl, .brEq(memBrEq), .brLt(memBrLt),
        .redirect, .branchResolved, .actualTaken, .mispredict
    );

    assign aluOp     = exCtrl.aluOp;
    assign aluASel   = exCtrl.aluASel;
    assign aluBSel   = exCtrl.aluBSel;
    assign memFunct3 = memCtrl.funct3;
    assign memWrite  = memCtrl.memWrite;
    assign regWen    = wbCtrl.regWen;
    assign wbSel     = wbCtrl.wbSel;
    assign wbRd      = wbCtrl.rd;

endmodule

`default_nettype wire

//--- pipeCtrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

// Invariants on the control path outputs
module pipeCtrlSva (
    input logic       clk,
    input logic       rst,
    input logic       stall,
    input logic       redirect,
    input logic [1:0] fwdA,
    input logic [1:0] fwdB,
    input logic [1:0] fwdStore,
    input logic       regWen,
    input logic       branchResolved,
    input logic       mispredict
);

    // Redirect wins over a load-use stall
    noStallOnRedirect: assert property (@(posedge clk) disable iff (rst)
        !(stall && redirect))
        else $error("stall and redirect high in the same cycle");

    fwdCodeLegal: assert property (@(posedge clk) disable iff (rst)
        fwdA != 2'd3 && fwdB != 2'd3 && fwdStore != 2'd3)
        else $error("forwarding select holds the unused code 3");

    regWenLowAfterReset: assert property (@(posedge clk)
        rst |=> !regWen)
        else $error("regWen high in the cycle after reset");

    mispredictIsBranch: assert property (@(posedge clk) disable iff (rst)
        mispredict |-> branchResolved)
        else $error("mispredict without a resolved branch");

endmodule

bind pipeCtrl pipeCtrlSva i_pipeCtrlSva (.*);

`default_nettype wire

//--- tbPipeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tbPipeCtrl;
    import rvIsaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod   = 20;
    localparam int resetCycles = 16;
    localparam int numInstr    = 400;
    localparam int limitCycles = resetCycles + 2 * numInstr + 20;
    localparam int numTests    = 6;
    localparam int tReset      = 0;
    localparam int tTiming     = 1;
    localparam int tFwd        = 2;
    localparam int tStall      = 3;
    localparam int tBranch     = 4;
    localparam int tFlush      = 5;

    logic                clk;
    logic                rst;
    logic [xlen-1:0]     instr;
    logic                predTaken;
    logic                brEq;
    logic                brLt;
    immSelT              immSel;
    aluOpT               aluOp;
    logic                aluASel;
    logic                aluBSel;
    logic [funct3W-1:0]  memFunct3;
    logic                memWrite;
    logic                regWen;
    wbSelT               wbSel;
    logic [regAddrW-1:0] wbRd;
    fwdSelT              fwdA;
    fwdSelT              fwdB;
    fwdSelT              fwdStore;
    logic                stall;
    logic                redirect;
    logic                branchResolved;
    logic                actualTaken;
    logic                mispredict;

    // Model of the stage registers
    exCtrlT  exW;
    logic    exLoad;
    memCtrlT memW;
    wbCtrlT  wbW;
    logic    brEqR;
    logic    brLtR;
    exCtrlT  heldW;            // Instruction kept in ID by a stall
    int      postStall;
    logic    lastStall;
    logic [3:0] memDue;        // Flushed slots still to reach MEM
    logic [3:0] wbDue;
    int      cycleCount;
    int      accepted;
    int      checks [numTests];
    int      errs   [numTests];
    string   testNames [numTests] = '{"reset", "stageTiming", "forwarding",
                                      "loadUseStall", "branchResolution", "flush"};

    pipeCtrl i_pipeCtrl (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(limitCycles * clkPeriod);
        $display("Timeout: run still going after %0d cycles", limitCycles);
        $display("Regression failed");
        $finish;
    end

    task automatic checkVal(input int testId, input string what,
                            input logic [31:0] expVal, input logic [31:0] actVal);
        checks[testId]++;
        if (expVal !== actVal) begin
            errs[testId]++;
            $display("CHECK FAILED %s %s at %0t: expected 0x%0h, actual 0x%0h",
                     testNames[testId], what, $time, expVal, actVal);
        end
    endtask

    task automatic reportTest(input int testId);
        $display("Test %-16s %0d checks, %0d errors", testNames[testId], checks[testId],
                 errs[testId]);
    endtask

    // ========================================================================
    // Reference decode, from the RV32I field rules
    // ========================================================================
    function automatic aluOpT expAluOp(input logic [2:0] f3, input logic bit30,
                                       input logic regForm);
        case (f3)
            3'd0:    return (regForm && bit30) ? aluSub : aluAdd;   // No SUBI
            3'd1:    return aluSll;
            3'd2:    return aluSlt;
            3'd3:    return aluSltu;
            3'd4:    return aluXor;
            3'd5:    return bit30 ? aluSra : aluSrl;
            3'd6:    return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    function automatic immSelT expImmSel(input logic [xlen-1:0] ins);
        case (ins[6:0])
            opStore:        return immS;
            opBranch:       return immB;
            opJal:          return immJ;
            opLui, opAuipc: return immU;
            default:        return immI;
        endcase
    endfunction

    function automatic exCtrlT expDecode(input logic [xlen-1:0] ins, input logic pred);
        exCtrlT w;
        logic   isLd;
        logic   isSt;
        logic   isBr;
        logic   isJmp;
        logic   isAlu;
        logic   hasRd;
        isLd  = ins[6:0] == opLoad;
        isSt  = ins[6:0] == opStore;
        isBr  = ins[6:0] == opBranch;
        isJmp = ins[6:0] == opJal || ins[6:0] == opJalr;
        isAlu = ins[6:0] == opOp || ins[6:0] == opOpImm;
        hasRd = isLd || isJmp || isAlu || ins[6:0] == opLui || ins[6:0] == opAuipc;
        w = '0;
        w.aluASel = isBr || ins[6:0] == opJal || ins[6:0] == opAuipc;   // PC relative
        w.aluBSel = (hasRd || isSt || isBr) && ins[6:0] != opOp;
        w.useRs1  = isLd || isSt || isBr || isAlu || ins[6:0] == opJalr;
        w.useRs2  = isSt || isBr || ins[6:0] == opOp;
        w.rs1     = w.useRs1 ? ins[19:15] : '0;
        w.rs2     = w.useRs2 ? ins[24:20] : '0;
        if (isAlu) begin
            w.aluOp = expAluOp(ins[14:12], ins[30], ins[6:0] == opOp);
        end
        w.mem.funct3    = (isLd || isSt || isBr) ? ins[14:12] : '0;
        w.mem.memWrite  = isSt;
        w.mem.isBranch  = isBr;
        w.mem.isJump    = isJmp;
        w.mem.predTaken = (isBr || isJmp) && pred;
        w.mem.wb.rd     = hasRd ? ins[11:7] : '0;
        w.mem.wb.regWen = hasRd && ins[11:7] != '0;
        if (isJmp) begin
            w.mem.wb.wbSel = wbPc4;
        end else if ((hasRd || isSt || isBr) && !isLd) begin
            w.mem.wb.wbSel = wbAlu;
        end
        return w;
    endfunction

    function automatic logic branchCond(input logic [2:0] f3, input logic eq, input logic lt);
        case (f3)
            f3Beq:         return eq;
            f3Bne:         return !eq;
            f3Blt, f3Bltu: return lt;
            default:       return !lt;     // bge, bgeu
        endcase
    endfunction

    // Newest writer first, x0 and unused sources never forwarded
    function automatic fwdSelT fwdSource(input logic [regAddrW-1:0] rs, input logic used);
        if (!used || rs == '0) begin
            return fwdNone;
        end
        if (memW.wb.regWen && memW.wb.rd == rs) begin
            return fwdMem;
        end
        if (wbW.regWen && wbW.rd == rs) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    function automatic logic [xlen-1:0] randInstr();
        logic [xlen-1:0] w;
        w = $urandom();
        case ($urandom_range(8))
            0:       w[6:0] = opLoad;
            1:       w[6:0] = opStore;
            2:       w[6:0] = opBranch;
            3:       w[6:0] = opJal;
            4:       w[6:0] = opJalr;
            5:       w[6:0] = opOpImm;
            6:       w[6:0] = opOp;
            7:       w[6:0] = opLui;
            default: w[6:0] = opAuipc;
        endcase
        // x0 to x7 only, so hazards are frequent
        w[11:10] = 2'b00;
        w[19:18] = 2'b00;
        w[24:23] = 2'b00;
        if (w[6:0] == opBranch && w[14:13] == 2'b01) begin
            w[14] = 1'b1;   // 010 and 011 are no branch
        end
        return w;
    endfunction

    // ========================================================================
    // One clock cycle: drive, check, advance the model
    // ========================================================================
    task automatic stepCycle(input logic [xlen-1:0] ins, input logic pred);
        exCtrlT              idW;
        logic                taken;
        logic                redir;
        logic                resolved;
        logic                misp;
        logic                loadUse;
        logic                expStall;
        logic [regAddrW-1:0] ldRd;
        fwdSelT              expA;
        fwdSelT              expRs2;
        instr     = ins;
        predTaken = pred;
        brEq      = 1'($urandom_range(1));
        brLt      = 1'($urandom_range(1));
        #(clkPeriod / 4);
        idW      = expDecode(ins, pred);
        taken    = 1'b0;
        redir    = 1'b0;
        resolved = 1'b0;
        misp     = 1'b0;
        if (memW.isJump) begin
            taken = 1'b1;
            redir = !memW.predTaken;
        end else if (memW.isBranch) begin
            resolved = 1'b1;
            taken    = branchCond(memW.funct3, brEqR, brLtR);
            misp     = taken != memW.predTaken;
            redir    = misp;
        end
        ldRd     = exW.mem.wb.rd;
        loadUse  = exLoad && ldRd != '0 && ((idW.useRs1 && idW.rs1 == ldRd)
                                            || (idW.useRs2 && idW.rs2 == ldRd));
        expStall = loadUse && !redir;
        expA     = fwdSource(exW.rs1, exW.useRs1);
        expRs2   = fwdSource(exW.rs2, exW.useRs2);

        if (cycleCount < 3) begin
            checkVal(tReset, "regWen", 0, regWen);      // First WB arrives after 3 edges
        end
        if (cycleCount < 2) begin
            checkVal(tReset, "memWrite", 0, memWrite);
            checkVal(tReset, "redirect", 0, redirect);
            checkVal(tReset, "mispredict", 0, mispredict);
        end
        checkVal(tTiming, "immSel", expImmSel(ins), immSel);
        checkVal(tTiming, "aluOp", exW.aluOp, aluOp);
        checkVal(tTiming, "aluASel", exW.aluASel, aluASel);
        checkVal(tTiming, "aluBSel", exW.aluBSel, aluBSel);
        checkVal(tTiming, "memFunct3", memW.funct3, memFunct3);
        checkVal(tTiming, "memWrite", memW.memWrite, memWrite);
        checkVal(tTiming, "regWen", wbW.regWen, regWen);
        checkVal(tTiming, "wbSel", wbW.wbSel, wbSel);
        checkVal(tTiming, "wbRd", wbW.rd, wbRd);
        checkVal(tFwd, "fwdA", expA, fwdA);
        checkVal(tFwd, "fwdB", exW.mem.memWrite ? fwdNone : expRs2, fwdB);
        checkVal(tFwd, "fwdStore", exW.mem.memWrite ? expRs2 : fwdNone, fwdStore);
        checkVal(tStall, "stall", expStall, stall);
        if (postStall == 1) begin
            checkVal(tStall, "exBubble", 0, {aluOp, aluASel, aluBSel});
        end else if (postStall == 2) begin
            checkVal(tStall, "exHeld", {heldW.aluOp, heldW.aluASel, heldW.aluBSel},
                     {aluOp, aluASel, aluBSel});
        end
        checkVal(tBranch, "redirect", redir, redirect);
        checkVal(tBranch, "branchResolved", resolved, branchResolved);
        checkVal(tBranch, "actualTaken", taken, actualTaken);
        checkVal(tBranch, "mispredict", misp, mispredict);
        if (memDue[0]) begin
            checkVal(tFlush, "memWrite", 0, memWrite);
        end
        if (wbDue[0]) begin
            checkVal(tFlush, "regWen", 0, regWen);
        end

        memDue = memDue >> 1;
        wbDue  = wbDue >> 1;
        if (redir) begin
            memDue = memDue | 4'b0011;  // Old EX then old ID
            wbDue  = wbDue | 4'b0110;
        end
        if (expStall) begin
            heldW     = idW;
            postStall = 1;
        end else if (postStall == 1) begin
            postStall = 2;
        end else begin
            postStall = 0;
        end
        wbW    = memW.wb;
        memW   = redir ? '0 : exW.mem;
        exLoad = (redir || expStall) ? 1'b0 : ins[6:0] == opLoad;
        exW    = (redir || expStall) ? '0 : idW;
        brEqR  = brEq;
        brLtR  = brLt;
        lastStall = expStall;
        cycleCount++;
        if (cycleCount == 3) begin
            reportTest(tReset);
        end
        @(negedge clk);
    endtask

    initial begin
        int              seedSink;
        int              totalChecks;
        int              totalErrs;
        logic [xlen-1:0] nextInstr;
        logic            nextPred;
        seedSink   = $urandom(9);
        rst        = 1'b1;
        instr      = '0;
        predTaken  = 1'b0;
        brEq       = 1'b0;
        brLt       = 1'b0;
        exW        = '0;
        exLoad     = 1'b0;
        memW       = '0;
        wbW        = '0;
        brEqR      = 1'b0;
        brLtR      = 1'b0;
        heldW      = '0;
        postStall  = 0;
        lastStall  = 1'b0;
        memDue     = '0;
        wbDue      = '0;
        cycleCount = 0;
        accepted   = 0;
        foreach (checks[i]) begin
            checks[i] = 0;
            errs[i]   = 0;
        end

        repeat (resetCycles) begin
            @(negedge clk);
            checkVal(tReset, "regWen", 0, regWen);
            checkVal(tReset, "memWrite", 0, memWrite);
            checkVal(tReset, "stall", 0, stall);
            checkVal(tReset, "redirect", 0, redirect);
            checkVal(tReset, "mispredict", 0, mispredict);
        end
        rst = 1'b0;

        nextInstr = randInstr();
        nextPred  = 1'($urandom_range(1));
        while (accepted < numInstr) begin
            stepCycle(nextInstr, nextPred);
            if (!lastStall) begin       // Held in ID otherwise
                accepted++;
                nextInstr = randInstr();
                nextPred  = 1'($urandom_range(1));
            end
        end
        repeat (4) stepCycle('0, 1'b0);     // Drain with no-ops

        totalChecks = 0;
        totalErrs   = 0;
        for (int i = 0; i < numTests; i++) begin
            if (i != tReset) begin
                reportTest(i);
            end
            totalChecks += checks[i];
            totalErrs   += errs[i];
        end
        $display("Summary: %0d instructions, %0d checks, %0d errors", accepted, totalChecks,
                 totalErrs);
        if (totalErrs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rvIsaPkg.sv
ctrlPkg.sv
stageIf.sv
instrDecoder.sv
pipeReg.sv
hazardUnit.sv
branchResolver.sv
pipeCtrl.sv
pipeCtrl_sva.sv
tbPipeCtrl.sv

//--- Bender.yml
package:
  name: pipe_ctrl

sources:
  - rvIsaPkg.sv
  - ctrlPkg.sv
  - stageIf.sv
  - instrDecoder.sv
  - pipeReg.sv
  - hazardUnit.sv
  - branchResolver.sv
  - pipeCtrl.sv
  - target: test
    files:
      - pipeCtrl_sva.sv
      - tbPipeCtrl.sv
